//--- arb_pkg.sv
// ####################
// Four requesters; scheme codes 6 and 7 are left undefined and grant nothing
// ####################
package arb_pkg;

  localparam int num_req = 4;   // Requesters, sizes req and gnt vectors
  localparam int sel_w   = 3;   // Scheme code width
  localparam int idx_w   = 2;   // Requester index width

  // Fixed orders, code k puts line k first then the rest ascending
  localparam logic [sel_w-1:0] arb_fix0 = 3'd0;
  localparam logic [sel_w-1:0] arb_fix1 = 3'd1;
  localparam logic [sel_w-1:0] arb_fix2 = 3'd2;
  localparam logic [sel_w-1:0] arb_fix3 = 3'd3;

  localparam logic [sel_w-1:0] arb_rr   = 3'd4;   // Round robin after last grant
  localparam logic [sel_w-1:0] arb_rand = 3'd5;   // Order picked by the shift register

endpackage

//--- pn_seq_gen.sv
// ####################
// Free running, advances every cycle whether or not anyone requests
// ####################
module pn_seq_gen import arb_pkg::*; (
  input  logic             clk,
  input  logic             rst_n,
  output logic [idx_w-1:0] rand_idx
);

  logic s1;
  logic s2;
  logic s3;

  // x^3 + x^2 + 1 style feedback, 7 states
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1 <= 1'b1;
      s2 <= 1'b0;
      s3 <= 1'b0;
    end else begin
      s1 <= s1 ^ s3;
      s2 <= s1;
      s3 <= s2;
    end
  end

  assign rand_idx = {s3, s2};   // Upper two bits of the chain

  // Lock-up state would freeze the random scheme on fixed order 0
  a_state_nonzero: assert property (
    @(posedge clk) disable iff (!rst_n)
    {s1, s2, s3} != 3'b000
  );

endmodule

//--- req_pending.sv
// ####################
// A strobe in the same cycle as its own grant keeps the line pending
// ####################
module req_pending import arb_pkg::*; (
  input  logic               clk,
  input  logic               rst_n,
  input  logic [num_req-1:0] req,
  input  logic [num_req-1:0] gnt_next,
  output logic [num_req-1:0] pending
);

  // Sticky bit per line
  // Cleared on the edge that registers the grant, set by a new strobe
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pending <= '0;
    end else begin
      pending <= (pending & ~gnt_next) | req;   // Set wins over clear
    end
  end

  // Selector must only pick among held lines
  a_gnt_from_pending: assert property (
    @(posedge clk) disable iff (!rst_n)
    (gnt_next & ~pending) == '0
  );

endmodule

//--- arb_select.sv
// ####################
// Purely combinational grant; registered downstream in grant_reg
// Only one line wins per cycle, undefined scheme codes grant nothing
// ####################
module arb_select import arb_pkg::*; (
  input  logic               clk,
  input  logic               rst_n,
  input  logic [num_req-1:0] pending,
  input  logic [sel_w-1:0]   arb_type,
  input  logic [idx_w-1:0]   last_idx,
  output logic [num_req-1:0] gnt_next
);

  logic [idx_w-1:0]   rand_idx;
  logic [idx_w-1:0]   rr_start;
  logic [num_req-1:0] gnt_fix0;
  logic [num_req-1:0] gnt_fix1;
  logic [num_req-1:0] gnt_fix2;
  logic [num_req-1:0] gnt_fix3;
  logic [num_req-1:0] gnt_rr;
  logic [num_req-1:0] gnt_rand;

  // Line first wins if set, else lowest pending index
  function automatic logic [num_req-1:0] fix_pick(
    input logic [num_req-1:0] req_v,
    input logic [idx_w-1:0]   first
  );
    logic [num_req-1:0] pick;
    pick = '0;
    for (int i = num_req - 1; i >= 0; i--) begin
      if (req_v[i]) begin
        pick = num_req'(1) << i;
      end
    end
    if (req_v[first]) begin
      pick = num_req'(1) << first;
    end
    return pick;
  endfunction

  // Circular scan from start, wraps modulo num_req
  function automatic logic [num_req-1:0] rr_pick(
    input logic [num_req-1:0] req_v,
    input logic [idx_w-1:0]   start
  );
    logic [num_req-1:0] pick;
    logic [idx_w-1:0]   idx;
    pick = '0;
    // Walk backwards so the nearest line after start overwrites
    for (int off = num_req - 1; off >= 0; off--) begin
      idx = start + idx_w'(off);
      if (req_v[idx]) begin
        pick = num_req'(1) << idx;
      end
    end
    return pick;
  endfunction

  pn_seq_gen u_pn_seq_gen (
    .clk      (clk),
    .rst_n    (rst_n),
    .rand_idx (rand_idx)
  );

  assign gnt_fix0 = fix_pick(pending, 2'd0);
  assign gnt_fix1 = fix_pick(pending, 2'd1);
  assign gnt_fix2 = fix_pick(pending, 2'd2);
  assign gnt_fix3 = fix_pick(pending, 2'd3);

  assign rr_start = last_idx + idx_w'(1);   // Empty last grant encodes as 0
  assign gnt_rr   = rr_pick(pending, rr_start);

  // Same order as fixed scheme rand_idx
  assign gnt_rand = fix_pick(pending, rand_idx);

  always_comb begin
    case (arb_type)
      arb_fix0: gnt_next = gnt_fix0;
      arb_fix1: gnt_next = gnt_fix1;
      arb_fix2: gnt_next = gnt_fix2;
      arb_fix3: gnt_next = gnt_fix3;
      arb_rr:   gnt_next = gnt_rr;
      arb_rand: gnt_next = gnt_rand;
      default:  gnt_next = '0;   // Codes 6 and 7
    endcase
  end

  a_gnt_onehot: assert property (
    @(posedge clk) disable iff (!rst_n)
    $onehot0(gnt_next)
  );

  // Anything pending under a defined scheme must be served this cycle
  a_no_idle_grant: assert property (
    @(posedge clk) disable iff (!rst_n)
    ((pending != '0) && (arb_type <= arb_rand)) |-> (gnt_next != '0)
  );

endmodule

//--- grant_reg.sv
// ####################
// last_idx follows gnt directly, a cycle with no grant resets it to 0
// ####################
module grant_reg import arb_pkg::*; (
  input  logic               clk,
  input  logic               rst_n,
  input  logic [num_req-1:0] gnt_next,
  output logic [num_req-1:0] gnt,
  output logic [idx_w-1:0]   last_idx
);

  // One-cycle grant pulse
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      gnt <= '0;
    end else begin
      gnt <= gnt_next;
    end
  end

  // OR encoder, valid since gnt is one-hot or zero
  always_comb begin
    last_idx = '0;
    for (int i = 0; i < num_req; i++) begin
      if (gnt[i]) begin
        last_idx = last_idx | idx_w'(i);
      end
    end
  end

  // End to end through the top: a pulse on gnt means that line was held
  // on the previous edge
  a_gnt_was_pending: assert property (
    @(posedge clk) disable iff (!rst_n)
    (gnt != '0) |-> ((gnt & ~$past(arb_top.pending)) == '0)
  );

endmodule

//--- arb_top.sv
// ####################
// Strobe to grant is one cycle at best, losers wait in pending
// ####################
module arb_top import arb_pkg::*; (
  input  logic               clk,
  input  logic               rst_n,
  input  logic [num_req-1:0] req,
  input  logic [sel_w-1:0]   arb_type,
  output logic [num_req-1:0] gnt,
  output logic [num_req-1:0] pending
);

  logic [num_req-1:0] gnt_next;   // Combinational pick, registered below
  logic [idx_w-1:0]   last_idx;   // Round robin feedback

  req_pending u_req_pending (
    .clk      (clk),
    .rst_n    (rst_n),
    .req      (req),
    .gnt_next (gnt_next),
    .pending  (pending)
  );

  arb_select u_arb_select (
    .clk      (clk),
    .rst_n    (rst_n),
    .pending  (pending),
    .arb_type (arb_type),
    .last_idx (last_idx),
    .gnt_next (gnt_next)
  );

  grant_reg u_grant_reg (
    .clk      (clk),
    .rst_n    (rst_n),
    .gnt_next (gnt_next),
    .gnt      (gnt),
    .last_idx (last_idx)
  );

endmodule

//--- clk_gen.sv
// ####################
// Free running, period 20, starts low
// ####################
module clk_gen (
  output logic clk
);

  initial begin
    clk = 1'b0;
  end

  always #10 clk = ~clk;   // Half period

endmodule

//--- arb_tb.sv
// ####################
// Model tracks the DUT from reset, so every clock edge goes through run_cycle
// ####################
module arb_tb import arb_pkg::*; ();

  localparam int reset_cycles  = 5;
  localparam int drain_limit   = 8;    // Cycles allowed to empty pending
  localparam int rr_wait_limit = 6;    // Round robin serves a line within 4 grants
  localparam int long_cycles   = 3000;
  localparam int rr_cycles     = 1000;

  logic               clk;
  logic               rst_n;
  logic [num_req-1:0] req;
  logic [sel_w-1:0]   arb_type;
  logic [num_req-1:0] gnt;
  logic [num_req-1:0] pending;

  // Reference model state
  logic [num_req-1:0] m_pending;
  logic [num_req-1:0] m_gnt;
  logic               m_s1;
  logic               m_s2;
  logic               m_s3;
  logic [1:0]         m_rand_used;   // Random index used at the last edge

  logic [31:0]        lcg_state;
  string              test_name;
  int                 check_cnt;
  int                 mismatch_cnt;
  int                 other_cnt;

  logic [num_req-1:0] held;
  logic [num_req-1:0] r;
  logic [num_req-1:0] exp_first;
  int                 age [num_req];

  clk_gen u_clk_gen (
    .clk (clk)
  );

  arb_top DUT (
    .clk      (clk),
    .rst_n    (rst_n),
    .req      (req),
    .arb_type (arb_type),
    .gnt      (gnt),
    .pending  (pending)
  );

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  // Each line strobes with probability one in four
  function automatic logic [num_req-1:0] random_req();
    logic [31:0]        v;
    logic [num_req-1:0] s;
    v = lcg_next();
    for (int i = 0; i < num_req; i++) begin
      s[i] = (v[16 + 2 * i +: 2] == 2'b00);
    end
    return s;
  endfunction

  function automatic logic [sel_w-1:0] random_type();
    logic [31:0] v;
    v = lcg_next();
    if (v[27:24] == 4'd0) begin
      return v[16] ? 3'd7 : 3'd6;   // Rare undefined code
    end
    return sel_w'(v[31:16] % 6);
  endfunction

  // Line first, then the others ascending
  function automatic logic [num_req-1:0] fixed_order_pick(
    input logic [num_req-1:0] pend,
    input int                 first
  );
    logic [num_req-1:0] pick;
    pick = '0;
    if (pend[first]) begin
      pick[first] = 1'b1;
    end else begin
      for (int i = 0; i < num_req; i++) begin
        if (pend[i] && pick == '0) begin
          pick[i] = 1'b1;
        end
      end
    end
    return pick;
  endfunction

  function automatic logic [num_req-1:0] rr_order_pick(
    input logic [num_req-1:0] pend,
    input int                 start
  );
    logic [num_req-1:0] pick;
    int                 idx;
    pick = '0;
    for (int off = 0; off < num_req; off++) begin
      idx = (start + off) % num_req;
      if (pend[idx] && pick == '0) begin
        pick[idx] = 1'b1;
      end
    end
    return pick;
  endfunction

  function automatic int encode_gnt(input logic [num_req-1:0] g);
    int e;
    e = 0;   // No grant encodes as 0
    for (int i = 0; i < num_req; i++) begin
      if (g[i]) begin
        e = i;
      end
    end
    return e;
  endfunction

  // One rising edge of the model
  task automatic model_step(input logic [num_req-1:0] s, input logic [sel_w-1:0] t);
    logic [num_req-1:0] pick;
    int                 start;
    start = (encode_gnt(m_gnt) + 1) % num_req;
    m_rand_used = {m_s3, m_s2};
    case (t)
      arb_fix0, arb_fix1, arb_fix2, arb_fix3: pick = fixed_order_pick(m_pending, int'(t));
      arb_rr:   pick = rr_order_pick(m_pending, start);
      arb_rand: pick = fixed_order_pick(m_pending, int'(m_rand_used));
      default:  pick = '0;
    endcase
    m_pending = (m_pending & ~pick) | s;   // Strobe wins over clear
    m_gnt = pick;
    {m_s1, m_s2, m_s3} = {m_s1 ^ m_s3, m_s1, m_s2};
  endtask

  task automatic report_mismatch(
    input string              what,
    input logic [num_req-1:0] exp_v,
    input logic [num_req-1:0] act_v
  );
    mismatch_cnt++;
    $display("mismatch %s %s: expected %b actual %b", test_name, what, exp_v, act_v);
  endtask

  // Drive at +2 after the edge, check at +1 after the next one
  task automatic run_cycle(input logic [num_req-1:0] s, input logic [sel_w-1:0] t);
    req      = s;
    arb_type = t;
    @(posedge clk);
    model_step(s, t);
    #1;
    check_cnt++;
    if (gnt !== m_gnt) begin
      report_mismatch("gnt", m_gnt, gnt);
    end
    if (pending !== m_pending) begin
      report_mismatch("pending", m_pending, pending);
    end
    if ((gnt & pending & ~s) != '0) begin
      report_mismatch("granted bit still pending", '0, gnt & pending & ~s);
    end
    if ($countones(gnt) > 1) begin
      other_cnt++;
      $display("%s: gnt has more than one bit set (%b)", test_name, gnt);
    end
    #1;
  endtask

  task automatic drain(input logic [sel_w-1:0] t, input int limit);
    int n;
    n = 0;
    while (pending != '0 && n < limit) begin
      run_cycle('0, t);
      n++;
    end
    if (pending != '0) begin
      other_cnt++;
      $display("%s: timeout, lines %b still pending after %0d cycles",
               test_name, pending, limit);
    end
  endtask

  initial begin
    lcg_state    = 32'd42202;
    check_cnt    = 0;
    mismatch_cnt = 0;
    other_cnt    = 0;
    req          = '0;
    arb_type     = arb_fix0;
    rst_n        = 1'b0;
    m_pending    = '0;
    m_gnt        = '0;
    m_s1         = 1'b1;
    m_s2         = 1'b0;
    m_s3         = 1'b0;
    m_rand_used  = '0;

    repeat (reset_cycles) @(posedge clk);
    #2;
    rst_n = 1'b1;

    test_name = "reset";
    check_cnt++;
    if (gnt !== '0) begin
      report_mismatch("gnt", '0, gnt);
    end
    if (pending !== '0) begin
      report_mismatch("pending", '0, pending);
    end
    for (int code = 0; code < 8; code++) begin
      repeat (3) begin
        run_cycle('0, sel_w'(code));
        if (gnt !== '0) begin
          report_mismatch("idle gnt", '0, gnt);
        end
      end
    end

    test_name = "fixed";
    for (int k = 0; k < num_req; k++) begin
      run_cycle(4'b1111, sel_w'(k));
      run_cycle('0, sel_w'(k));
      if (gnt !== (4'b0001 << k)) begin
        report_mismatch("first grant", 4'b0001 << k, gnt);
      end
      drain(sel_w'(k), drain_limit);
      // Line k absent, lowest remaining line goes first
      exp_first = (k == 0) ? 4'b0010 : 4'b0001;
      run_cycle(4'b1111 & ~(4'b0001 << k), sel_w'(k));
      run_cycle('0, sel_w'(k));
      if (gnt !== exp_first) begin
        report_mismatch("first grant without line k", exp_first, gnt);
      end
      drain(sel_w'(k), drain_limit);
    end

    // Starts empty with last_idx 0, so line 1 is served first
    test_name = "round_robin";
    for (int n = 0; n < 12; n++) begin
      run_cycle(4'b1111, arb_rr);
      if (n > 0 && gnt !== (4'b0001 << (n % num_req))) begin
        report_mismatch("rotation", 4'b0001 << (n % num_req), gnt);
      end
    end
    drain(arb_rr, drain_limit);

    test_name = "random";
    for (int n = 0; n < 16; n++) begin
      run_cycle(4'b1111, arb_rand);
      if (n > 0 && gnt !== (4'b0001 << m_rand_used)) begin
        report_mismatch("shift register order", 4'b0001 << m_rand_used, gnt);
      end
    end
    drain(arb_rr, drain_limit);

    test_name = "undefined";
    held = 4'b0110;
    for (int code = 6; code < 8; code++) begin
      run_cycle(held, sel_w'(code));
      repeat (4) begin
        run_cycle('0, sel_w'(code));
        if (gnt !== '0) begin
          report_mismatch("gnt", '0, gnt);
        end
        if (pending !== held) begin
          report_mismatch("held pending", held, pending);
        end
      end
    end
    drain(arb_rr, drain_limit);

    test_name = "long_random";
    for (int n = 0; n < long_cycles; n++) begin
      r = random_req();
      run_cycle(r, random_type());
    end

    // Cycles each line has waited since its last grant
    test_name = "rr_service";
    for (int i = 0; i < num_req; i++) begin
      age[i] = 0;
    end
    for (int n = 0; n < rr_cycles; n++) begin
      r = random_req();
      run_cycle(r, arb_rr);
      for (int i = 0; i < num_req; i++) begin
        if (gnt[i] || !pending[i]) begin
          age[i] = 0;
        end else begin
          age[i]++;
        end
        if (age[i] == rr_wait_limit + 1) begin
          other_cnt++;
          $display("%s: line %0d waited more than %0d cycles for its grant",
                   test_name, i, rr_wait_limit);
        end
      end
    end
    drain(arb_rr, drain_limit);

    $display("checks %0d, mismatches %0d, other errors %0d",
             check_cnt, mismatch_cnt, other_cnt);
    if (mismatch_cnt == 0 && other_cnt == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

//--- arb_top.f
arb_pkg.sv
pn_seq_gen.sv
req_pending.sv
arb_select.sv
grant_reg.sv
arb_top.sv
clk_gen.sv
arb_tb.sv

//--- Bender.yml
package:
  name: arb_top

sources:
  - arb_pkg.sv
  - pn_seq_gen.sv
  - req_pending.sv
  - arb_select.sv
  - grant_reg.sv
  - arb_top.sv
  - target: simulation
    files:
      - clk_gen.sv
      - arb_tb.sv
